/* source/csr_pkg.sv */
// machine CSR unit definitions
`default_nettype none

package csr_pkg;

    typedef logic [31:0] xlen_t;        // data word, pc and csr values
    typedef logic [11:0] csr_addr_t;    // csr index
    typedef logic [2:0]  funct3_t;      // instruction function field
    typedef logic [3:0]  cause_t;       // mcause exception code
    typedef logic [5:0]  opcode_t;      // one-hot opcode class

    // bit positions inside opcode_t
    localparam int OPC_LOAD   = 0;
    localparam int OPC_STORE  = 1;
    localparam int OPC_BRANCH = 2;
    localparam int OPC_JAL    = 3;
    localparam int OPC_JALR   = 4;
    localparam int OPC_SYSTEM = 5;

    // csr operation codes, bit 2 selects the immediate operand
    localparam funct3_t F3_CSRRW  = 3'd1;
    localparam funct3_t F3_CSRRS  = 3'd2;
    localparam funct3_t F3_CSRRC  = 3'd3;
    localparam funct3_t F3_CSRRWI = 3'd5;
    localparam funct3_t F3_CSRRSI = 3'd6;
    localparam funct3_t F3_CSRRCI = 3'd7;

    localparam csr_addr_t ADDR_MVENDORID = 12'hF11;    // machine id, read zero
    localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID   = 12'hF14;
    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;    // trap setup
    localparam csr_addr_t ADDR_MISA      = 12'h301;
    localparam csr_addr_t ADDR_MIE       = 12'h304;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;    // trap handling
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t ADDR_MTVAL     = 12'h343;
    localparam csr_addr_t ADDR_MIP       = 12'h344;

    localparam cause_t CAUSE_INST_MISALIGNED  = 4'd0;  // exceptions
    localparam cause_t CAUSE_ILLEGAL          = 4'd2;
    localparam cause_t CAUSE_EBREAK           = 4'd3;
    localparam cause_t CAUSE_LOAD_MISALIGNED  = 4'd4;
    localparam cause_t CAUSE_STORE_MISALIGNED = 4'd6;
    localparam cause_t CAUSE_ECALL            = 4'd11;
    localparam cause_t CAUSE_SW_IRQ           = 4'd3;  // interrupts, mcause bit 31 set
    localparam cause_t CAUSE_EXT_IRQ          = 4'd11;

    localparam int BIT_MIE  = 3;    // mstatus global enable
    localparam int BIT_MPIE = 7;    // mstatus previous enable
    localparam int BIT_MSI  = 3;    // software irq in mie/mip
    localparam int BIT_MEI  = 11;   // external irq in mie/mip

    localparam xlen_t MISA_VALUE      = 32'h4000_0100;  // rv32, I extension
    localparam xlen_t TRAP_ADDR_RESET = 32'h0000_0000;  // mtvec after reset

endpackage

`default_nettype wire

/* source/trap_detect.sv */
// trap cause detection
`timescale 1ns/1ps
`default_nettype none

module trap_detect import csr_pkg::*; (
    input  wire opcode_t   i_opcode,      // one-hot opcode class
    input  wire funct3_t   i_funct3,      // access size for load/store
    input  wire csr_addr_t i_csr_index,   // low bits carry the jump offset
    input  wire xlen_t     i_pc,
    input  wire xlen_t     i_rs1,
    input  wire xlen_t     i_y,           // alu result, address or branch taken
    input  wire            i_illegal,
    input  wire            i_ecall,
    input  wire            i_ebreak,
    input  wire            i_ce,
    input  wire            i_global_ie,   // mstatus.MIE
    input  wire            i_ext_en,
    input  wire            i_sw_en,
    input  wire            i_ext_pend,
    input  wire            i_sw_pend,
    output logic           o_trap_req,
    output logic           o_is_irq,
    output cause_t         o_cause,
    output logic           o_save_tval    // mtval takes the faulting address
);

    logic       ld_mis;         // load address misaligned
    logic       st_mis;         // store address misaligned
    logic       inst_mis;       // jump/branch target misaligned
    logic       size_half;
    logic       size_word;
    logic       jump_taken;
    logic [1:0] target_lo;      // low bits of the jump target
    logic       ext_irq;
    logic       sw_irq;
    logic       exc_any;

    assign size_half = (i_funct3[1:0] == 2'b01);
    assign size_word = (i_funct3[1:0] == 2'b10);

    // halfword needs bit 0 clear, word needs both low bits clear
    assign ld_mis = i_opcode[OPC_LOAD] && ((size_half && i_y[0]) ||
                    (size_word && (i_y[1:0] != 2'b00)));
    assign st_mis = i_opcode[OPC_STORE] && ((size_half && i_y[0]) ||
                    (size_word && (i_y[1:0] != 2'b00)));

    // branch target only matters when taken, y bit 0 flags that
    assign jump_taken = (i_opcode[OPC_BRANCH] && i_y[0]) ||
                        i_opcode[OPC_JAL] || i_opcode[OPC_JALR];
    assign target_lo  = (i_opcode[OPC_JALR] ? i_rs1[1:0] : i_pc[1:0]) +
                        i_csr_index[1:0];                      // jalr bases on rs1
    assign inst_mis   = jump_taken && (target_lo != 2'b00);

    assign ext_irq = i_global_ie && i_ext_en && i_ext_pend;    // masked by both enables
    assign sw_irq  = i_global_ie && i_sw_en && i_sw_pend;

    assign exc_any = i_illegal || inst_mis || i_ecall || i_ebreak || ld_mis || st_mis;

    assign o_is_irq    = i_ce && (ext_irq || sw_irq);
    assign o_trap_req  = i_ce && (ext_irq || sw_irq || exc_any);
    assign o_save_tval = i_ce && (ld_mis || st_mis);

    // fixed priority, interrupts before exceptions
    always_comb begin
        if (ext_irq)
            o_cause = CAUSE_EXT_IRQ;
        else if (sw_irq)
            o_cause = CAUSE_SW_IRQ;
        else if (i_illegal)
            o_cause = CAUSE_ILLEGAL;
        else if (inst_mis)
            o_cause = CAUSE_INST_MISALIGNED;
        else if (i_ecall)
            o_cause = CAUSE_ECALL;
        else if (i_ebreak)
            o_cause = CAUSE_EBREAK;
        else if (ld_mis)
            o_cause = CAUSE_LOAD_MISALIGNED;
        else if (st_mis)
            o_cause = CAUSE_STORE_MISALIGNED;
        else
            o_cause = '0;                                      // no trap
    end

endmodule

`default_nettype wire

/* source/csr_regfile.sv */
// machine CSR storage
`timescale 1ns/1ps
`default_nettype none

module csr_regfile import csr_pkg::*; (
    input  wire            i_clk,
    input  wire            i_rst_n,
    input  wire            i_stall,       // memory/writeback hold
    input  wire            i_ce,
    input  wire opcode_t   i_opcode,
    input  wire funct3_t   i_funct3,
    input  wire csr_addr_t i_csr_index,
    input  wire xlen_t     i_imm,         // zero-extended uimm
    input  wire xlen_t     i_rs1,
    input  wire xlen_t     i_pc,
    input  wire xlen_t     i_y,
    input  wire            i_ext_irq,
    input  wire            i_sw_irq,
    input  wire            i_trap_take,   // single pulse per trap
    input  wire            i_ret_take,    // mret accepted
    input  wire            i_is_irq,
    input  wire cause_t    i_cause,
    input  wire            i_save_tval,
    output xlen_t          o_rdata,       // value at i_csr_index
    output xlen_t          o_mtvec,
    output xlen_t          o_mepc,
    output logic           o_global_ie,
    output logic           o_ext_en,
    output logic           o_sw_en,
    output logic           o_ext_pend,
    output logic           o_sw_pend
);

    logic   mstatus_mie;
    logic   mstatus_mpie;
    logic   mie_msie;
    logic   mie_meie;
    xlen_t  mtvec;          // base plus mode bit 0
    xlen_t  mscratch;
    xlen_t  mepc;
    logic   mcause_irq;     // mcause bit 31
    cause_t mcause_code;
    xlen_t  mtval;
    logic   mip_msip;
    logic   mip_meip;
    xlen_t  operand;        // rs1 or immediate
    xlen_t  csr_wdata;      // new value after read-modify-write
    logic   csr_we;

    assign csr_we  = i_opcode[OPC_SYSTEM] && (i_funct3 != 3'd0) && i_ce;
    assign operand = i_funct3[2] ? i_imm : i_rs1;    // upper half of funct3 codes use uimm

    // read mux, unknown indexes read zero
    always_comb begin
        o_rdata = '0;
        case (i_csr_index)
            ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID: o_rdata = '0;
            ADDR_MSTATUS: begin
                o_rdata[BIT_MIE]  = mstatus_mie;
                o_rdata[BIT_MPIE] = mstatus_mpie;
                o_rdata[12:11]    = 2'b11;                   // MPP, machine mode only
            end
            ADDR_MISA:     o_rdata = MISA_VALUE;
            ADDR_MIE: begin
                o_rdata[BIT_MSI] = mie_msie;
                o_rdata[BIT_MEI] = mie_meie;
            end
            ADDR_MTVEC:    o_rdata = mtvec;
            ADDR_MSCRATCH: o_rdata = mscratch;
            ADDR_MEPC:     o_rdata = mepc;
            ADDR_MCAUSE:   o_rdata = {mcause_irq, 27'd0, mcause_code};
            ADDR_MTVAL:    o_rdata = mtval;
            ADDR_MIP: begin
                o_rdata[BIT_MSI] = mip_msip;
                o_rdata[BIT_MEI] = mip_meip;
            end
            default:       o_rdata = '0;
        endcase
    end

    // write, set or clear against the current value
    always_comb begin
        case (i_funct3)
            F3_CSRRW, F3_CSRRWI: csr_wdata = operand;
            F3_CSRRS, F3_CSRRSI: csr_wdata = o_rdata | operand;
            F3_CSRRC, F3_CSRRCI: csr_wdata = o_rdata & ~operand;
            default:             csr_wdata = o_rdata;     // funct3 0 never writes
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_msie     <= 1'b0;
            mie_meie     <= 1'b0;
            mtvec        <= TRAP_ADDR_RESET;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_irq   <= 1'b0;
            mcause_code  <= '0;
            mtval        <= '0;
            mip_msip     <= 1'b0;
            mip_meip     <= 1'b0;
        end else if (!i_stall) begin
            // trap and mret win over a csr write to mstatus
            if (i_trap_take) begin
                mstatus_mie  <= 1'b0;
                mstatus_mpie <= mstatus_mie;                 // save old enable
            end else if (i_ret_take) begin
                mstatus_mie  <= mstatus_mpie;                // restore
                mstatus_mpie <= 1'b1;
            end else if (csr_we && i_csr_index == ADDR_MSTATUS) begin
                mstatus_mie  <= csr_wdata[BIT_MIE];
                mstatus_mpie <= csr_wdata[BIT_MPIE];
            end
            if (csr_we && i_csr_index == ADDR_MIE) begin
                mie_msie <= csr_wdata[BIT_MSI];
                mie_meie <= csr_wdata[BIT_MEI];
            end
            if (csr_we && i_csr_index == ADDR_MTVEC)
                mtvec <= {csr_wdata[31:2], 1'b0, csr_wdata[0]};  // mode 2/3 reserved
            if (csr_we && i_csr_index == ADDR_MSCRATCH)
                mscratch <= csr_wdata;
            if (i_trap_take)
                mepc <= i_pc;                                // faulting/interrupted pc
            else if (csr_we && i_csr_index == ADDR_MEPC)
                mepc <= {csr_wdata[31:2], 2'b00};
            if (i_trap_take) begin
                mcause_irq  <= i_is_irq;
                mcause_code <= i_cause;
            end else if (csr_we && i_csr_index == ADDR_MCAUSE) begin
                mcause_irq  <= csr_wdata[31];
                mcause_code <= csr_wdata[3:0];
            end
            if (i_trap_take && i_save_tval)
                mtval <= i_y;                                // misaligned data address
            else if (csr_we && i_csr_index == ADDR_MTVAL)
                mtval <= csr_wdata;
            mip_msip <= i_sw_irq;                            // pending sampled every update edge
            mip_meip <= i_ext_irq;
        end
    end

    assign o_mtvec     = mtvec;
    assign o_mepc      = mepc;
    assign o_global_ie = mstatus_mie;
    assign o_ext_en    = mie_meie;
    assign o_sw_en     = mie_msie;
    assign o_ext_pend  = mip_meip;
    assign o_sw_pend   = mip_msip;

endmodule

`default_nettype wire

/* source/trap_ctrl.sv */
// trap entry and return control
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl import csr_pkg::*; (
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire         i_stall,
    input  wire         i_ce,
    input  wire         i_mret,
    input  wire         i_trap_req,          // already qualified by ce
    input  wire         i_is_irq,
    input  wire cause_t i_cause,
    input  wire xlen_t  i_mtvec,
    input  wire xlen_t  i_mepc,
    input  wire xlen_t  i_rdata,
    output logic        o_trap_take,         // one pulse per trap request
    output logic        o_ret_take,
    output logic        o_go_to_trap_q,
    output logic        o_return_from_trap_q,
    output xlen_t       o_trap_address,
    output xlen_t       o_return_address,
    output xlen_t       o_csr_out            // csr read, one cycle late
);

    xlen_t trap_base;       // mtvec with mode bits cleared
    xlen_t vector_ofs;      // 4 * cause
    xlen_t trap_target;

    // q stays high while the request lasts, so a held request enters once
    assign o_trap_take = i_trap_req && !o_go_to_trap_q && !i_stall;
    assign o_ret_take  = i_mret && i_ce && !i_stall;

    assign trap_base   = {i_mtvec[31:2], 2'b00};
    assign vector_ofs  = {26'd0, i_cause, 2'b00};
    // vectored mode only redirects interrupts
    assign trap_target = (i_mtvec[0] && i_is_irq) ? trap_base + vector_ofs : trap_base;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_go_to_trap_q       <= 1'b0;
            o_return_from_trap_q <= 1'b0;
            o_trap_address       <= TRAP_ADDR_RESET;
            o_return_address     <= '0;
            o_csr_out            <= '0;
        end else if (!i_stall) begin
            o_go_to_trap_q       <= i_trap_req;
            o_return_from_trap_q <= o_ret_take;
            if (o_trap_take)
                o_trap_address <= trap_target;          // latched at trap entry only
            if (i_ce) begin
                o_return_address <= i_mepc;             // mepc before this edge
                o_csr_out        <= i_rdata;
            end
        end
    end

endmodule

`default_nettype wire

/* source/csr_unit.sv */
// machine CSR unit top
`timescale 1ns/1ps
`default_nettype none

module csr_unit import csr_pkg::*; (
    input  wire            i_clk,
    input  wire            i_rst_n,
    input  wire            i_ce,            // stage clock enable
    input  wire            i_stall,         // memory/writeback hold
    input  wire            i_ext_irq,
    input  wire            i_sw_irq,
    input  wire            i_illegal,       // decode flags, one cycle each
    input  wire            i_ecall,
    input  wire            i_ebreak,
    input  wire            i_mret,
    input  wire opcode_t   i_opcode,
    input  wire funct3_t   i_funct3,
    input  wire csr_addr_t i_csr_index,
    input  wire xlen_t     i_imm,
    input  wire xlen_t     i_rs1,
    input  wire xlen_t     i_pc,
    input  wire xlen_t     i_y,
    output xlen_t          o_csr_out,
    output xlen_t          o_trap_address,
    output xlen_t          o_return_address,
    output logic           o_go_to_trap_q,
    output logic           o_return_from_trap_q
);

    logic   global_ie;
    logic   ext_en;
    logic   sw_en;
    logic   ext_pend;
    logic   sw_pend;
    logic   trap_req;
    logic   is_irq;
    cause_t cause;
    logic   save_tval;
    logic   trap_take;
    logic   ret_take;
    xlen_t  mtvec;
    xlen_t  mepc;
    xlen_t  rdata;

    trap_detect u_trap_detect (
        .i_opcode    (i_opcode),
        .i_funct3    (i_funct3),
        .i_csr_index (i_csr_index),
        .i_pc        (i_pc),
        .i_rs1       (i_rs1),
        .i_y         (i_y),
        .i_illegal   (i_illegal),
        .i_ecall     (i_ecall),
        .i_ebreak    (i_ebreak),
        .i_ce        (i_ce),
        .i_global_ie (global_ie),
        .i_ext_en    (ext_en),
        .i_sw_en     (sw_en),
        .i_ext_pend  (ext_pend),
        .i_sw_pend   (sw_pend),
        .o_trap_req  (trap_req),
        .o_is_irq    (is_irq),
        .o_cause     (cause),
        .o_save_tval (save_tval)
    );

    csr_regfile u_csr_regfile (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_stall     (i_stall),
        .i_ce        (i_ce),
        .i_opcode    (i_opcode),
        .i_funct3    (i_funct3),
        .i_csr_index (i_csr_index),
        .i_imm       (i_imm),
        .i_rs1       (i_rs1),
        .i_pc        (i_pc),
        .i_y         (i_y),
        .i_ext_irq   (i_ext_irq),
        .i_sw_irq    (i_sw_irq),
        .i_trap_take (trap_take),
        .i_ret_take  (ret_take),
        .i_is_irq    (is_irq),
        .i_cause     (cause),
        .i_save_tval (save_tval),
        .o_rdata     (rdata),
        .o_mtvec     (mtvec),
        .o_mepc      (mepc),
        .o_global_ie (global_ie),
        .o_ext_en    (ext_en),
        .o_sw_en     (sw_en),
        .o_ext_pend  (ext_pend),
        .o_sw_pend   (sw_pend)
    );

    trap_ctrl u_trap_ctrl (
        .i_clk                (i_clk),
        .i_rst_n              (i_rst_n),
        .i_stall              (i_stall),
        .i_ce                 (i_ce),
        .i_mret               (i_mret),
        .i_trap_req           (trap_req),
        .i_is_irq             (is_irq),
        .i_cause              (cause),
        .i_mtvec              (mtvec),
        .i_mepc               (mepc),
        .i_rdata              (rdata),
        .o_trap_take          (trap_take),
        .o_ret_take           (ret_take),
        .o_go_to_trap_q       (o_go_to_trap_q),
        .o_return_from_trap_q (o_return_from_trap_q),
        .o_trap_address       (o_trap_address),
        .o_return_address     (o_return_address),
        .o_csr_out            (o_csr_out)
    );

endmodule

`default_nettype wire

/* tests/csr_unit_checker.sv */
// trap control assertions
`timescale 1ns/1ps
`default_nettype none

module csr_unit_checker import csr_pkg::*; (
    input wire        i_clk,
    input wire        i_rst_n,
    input wire        i_trap_take,
    input wire        i_go_to_trap_q,
    input wire        i_return_from_trap_q,
    input wire xlen_t i_trap_address
);

    int unsigned fail_count = 0;    // assertion failures so far

    trap_addr_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_trap_address[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("trap address is not word aligned");
        end

    // entry and return flags never high together
    trap_ret_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_go_to_trap_q && i_return_from_trap_q))
        else begin
            fail_count++;
            $error("go_to_trap and return_from_trap high together");
        end

    take_once: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_trap_take |=> !i_trap_take)   // a held request is taken on one edge only
        else begin
            fail_count++;
            $error("trap taken on two edges in a row");
        end

endmodule

bind trap_ctrl csr_unit_checker u_checker (
    .i_clk                (i_clk),
    .i_rst_n              (i_rst_n),
    .i_trap_take          (o_trap_take),
    .i_go_to_trap_q       (o_go_to_trap_q),
    .i_return_from_trap_q (o_return_from_trap_q),
    .i_trap_address       (o_trap_address)
);

`default_nettype wire

/* tests/tb_csr_unit.sv */
// CSR unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit import csr_pkg::*; ();

    logic      i_clk;
    logic      i_rst_n;
    logic      i_ce;
    logic      i_stall;
    logic      i_ext_irq;
    logic      i_sw_irq;
    logic      i_illegal;
    logic      i_ecall;
    logic      i_ebreak;
    logic      i_mret;
    opcode_t   i_opcode;
    funct3_t   i_funct3;
    csr_addr_t i_csr_index;
    xlen_t     i_imm;
    xlen_t     i_rs1;
    xlen_t     i_pc;
    xlen_t     i_y;
    xlen_t     o_csr_out;
    xlen_t     o_trap_address;
    xlen_t     o_return_address;
    logic      o_go_to_trap_q;
    logic      o_return_from_trap_q;

    int        error_count;
    int        check_count;
    xlen_t     lcg_state;
    xlen_t     mscratch_model;   // expected mscratch contents
    xlen_t     mepc_model;       // pc saved by the interrupt trap

    csr_unit u_dut (.*);

    initial i_clk = 1'b0;
    always #50 i_clk = ~i_clk;    // 100 ns period

    function automatic xlen_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected result of a csr write, set or clear
    function automatic xlen_t csr_rmw(funct3_t f3, xlen_t old, xlen_t operand);
        case (f3)
            F3_CSRRW, F3_CSRRWI: return operand;
            F3_CSRRS, F3_CSRRSI: return old | operand;
            F3_CSRRC, F3_CSRRCI: return old & ~operand;
            default:             return old;
        endcase
    endfunction

    // interrupts ahead of exceptions in fixed order
    function automatic cause_t expected_cause(logic ext, logic sw, logic ill, logic inst_mis,
                                              logic ecl, logic ebk, logic ld_mis,
                                              logic st_mis);
        if (ext)      return CAUSE_EXT_IRQ;
        if (sw)       return CAUSE_SW_IRQ;
        if (ill)      return CAUSE_ILLEGAL;
        if (inst_mis) return CAUSE_INST_MISALIGNED;
        if (ecl)      return CAUSE_ECALL;
        if (ebk)      return CAUSE_EBREAK;
        if (ld_mis)   return CAUSE_LOAD_MISALIGNED;
        if (st_mis)   return CAUSE_STORE_MISALIGNED;
        return '0;
    endfunction

    function automatic logic addr_misaligned(funct3_t f3, xlen_t addr);
        case (f3[1:0])
            2'b01:   return addr[0];                  // halfword
            2'b10:   return addr[1:0] != 2'b00;       // word
            default: return 1'b0;                     // byte never faults
        endcase
    endfunction

    function automatic opcode_t onehot_opcode(int pos);
        opcode_t v;
        v      = '0;
        v[pos] = 1'b1;
        return v;
    endfunction

    task automatic check_data(input string name, input xlen_t expected, input xlen_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_cause(input string name, input cause_t expected, input cause_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    task automatic step();
        @(posedge i_clk);
        #1;                                           // drive just after the edge
    endtask

    task automatic drive_idle();                      // empty stage with irq lines untouched
        i_ce        = 1'b1;
        i_stall     = 1'b0;
        i_illegal   = 1'b0;
        i_ecall     = 1'b0;
        i_ebreak    = 1'b0;
        i_mret      = 1'b0;
        i_opcode    = '0;
        i_funct3    = '0;
        i_csr_index = '0;
        i_imm       = '0;
        i_rs1       = '0;
        i_y         = '0;
    endtask

    // one csr instruction returning the value it read
    task automatic csr_op(input funct3_t f3, input csr_addr_t addr, input xlen_t rs1,
                          input xlen_t imm, output xlen_t old_val);
        i_opcode    = onehot_opcode(OPC_SYSTEM);
        i_funct3    = f3;
        i_csr_index = addr;
        i_rs1       = rs1;
        i_imm       = imm;
        step();
        old_val = o_csr_out;
        drive_idle();
    endtask

    task automatic csr_read(input csr_addr_t addr, output xlen_t val);
        i_csr_index = addr;
        step();
        val = o_csr_out;                              // one cycle read latency
        i_csr_index = '0;
    endtask

    task automatic wait_trap(input string name, output logic seen);
        seen = 1'b0;
        for (int i = 0; i < 20 && !seen; i++) begin
            step();
            seen = o_go_to_trap_q;
        end
        if (!seen)
            report_failure({name, ": no trap entry within 20 cycles"});
    endtask

    task automatic do_mret();
        i_mret = 1'b1;
        step();
        i_mret = 1'b0;
    endtask

    task automatic mscratch_rmw_ops();
        funct3_t ops [6] = '{F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI};
        xlen_t   rs1;
        xlen_t   imm;
        xlen_t   operand;
        xlen_t   rd;
        for (int round = 0; round < 3; round++) begin
            for (int k = 0; k < 6; k++) begin
                rs1     = lcg_next();
                imm     = lcg_next() & 32'h1F;        // 5-bit uimm
                operand = (ops[k] inside {F3_CSRRWI, F3_CSRRSI, F3_CSRRCI}) ? imm : rs1;
                csr_op(ops[k], ADDR_MSCRATCH, rs1, imm, rd);
                check_data($sformatf("mscratch old f3=%0d", ops[k]), mscratch_model, rd);
                mscratch_model = csr_rmw(ops[k], mscratch_model, operand);
                csr_read(ADDR_MSCRATCH, rd);
                check_data($sformatf("mscratch new f3=%0d", ops[k]), mscratch_model, rd);
            end
        end
        i_stall     = 1'b1;                           // write on a held edge is dropped
        i_opcode    = onehot_opcode(OPC_SYSTEM);
        i_funct3    = F3_CSRRW;
        i_csr_index = ADDR_MSCRATCH;
        i_rs1       = ~mscratch_model;
        step();
        drive_idle();
        csr_read(ADDR_MSCRATCH, rd);
        check_data("mscratch after stalled write", mscratch_model, rd);
    endtask

    task automatic read_only_csrs();
        csr_addr_t zero_addrs [6] = '{ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID,
                                      ADDR_MHARTID, 12'h7C0, 12'hB00};
        xlen_t     rd;
        csr_read(ADDR_MSTATUS, rd);
        check_data("mstatus after reset", 32'h0000_1800, rd);    // MPP = 3
        csr_read(ADDR_MISA, rd);
        check_data("misa", MISA_VALUE, rd);
        foreach (zero_addrs[k]) begin
            csr_read(zero_addrs[k], rd);
            check_data($sformatf("csr %h reads zero", zero_addrs[k]), '0, rd);
        end
        csr_op(F3_CSRRW, ADDR_MISA, lcg_next(), '0, rd);
        check_data("misa read by csrrw", MISA_VALUE, rd);
        csr_read(ADDR_MISA, rd);
        check_data("misa after write", MISA_VALUE, rd);
    endtask

    task automatic run_exception(input string name, input logic ill, input logic ecl,
                                 input logic ebk, input opcode_t opc, input funct3_t f3,
                                 input csr_addr_t ofs, input xlen_t y);
        cause_t exp_cause;
        logic   ld_mis;
        logic   st_mis;
        logic   jmp_mis;
        xlen_t  pc;
        xlen_t  rd;
        pc        = lcg_next() & ~32'h3;
        ld_mis    = opc[OPC_LOAD] && addr_misaligned(f3, y);
        st_mis    = opc[OPC_STORE] && addr_misaligned(f3, y);
        jmp_mis   = opc[OPC_JAL] && (ofs[1:0] != 2'b00);        // pc itself is aligned
        exp_cause = expected_cause(1'b0, 1'b0, ill, jmp_mis, ecl, ebk, ld_mis, st_mis);
        i_pc        = pc;
        i_illegal   = ill;
        i_ecall     = ecl;
        i_ebreak    = ebk;
        i_opcode    = opc;
        i_funct3    = f3;
        i_csr_index = ofs;
        i_y         = y;
        step();
        check_bit({name, " go_to_trap"}, 1'b1, o_go_to_trap_q);
        drive_idle();
        csr_read(ADDR_MCAUSE, rd);
        check_cause({name, " mcause"}, exp_cause, rd[3:0]);
        check_bit({name, " mcause irq bit"}, 1'b0, rd[31]);
        csr_read(ADDR_MEPC, rd);
        check_data({name, " mepc"}, pc, rd);
        if (ld_mis || st_mis) begin
            csr_read(ADDR_MTVAL, rd);
            check_data({name, " mtval"}, y, rd);
        end
    endtask

    task automatic exception_traps();
        opcode_t none;
        none = '0;
        run_exception("illegal", 1, 0, 0, none, 3'd0, '0, '0);
        run_exception("ecall", 0, 1, 0, none, 3'd0, '0, '0);
        run_exception("ebreak", 0, 0, 1, none, 3'd0, '0, '0);
        run_exception("ecall+ebreak", 0, 1, 1, none, 3'd0, '0, '0);
        run_exception("illegal+ecall+ebreak", 1, 1, 1, none, 3'd0, '0, '0);
        run_exception("jal misaligned", 0, 0, 0, onehot_opcode(OPC_JAL), 3'd0, 12'h002, '0);
        run_exception("jal misaligned+ecall", 0, 1, 0, onehot_opcode(OPC_JAL), 3'd0,
                      12'h001, '0);
        run_exception("load word", 0, 0, 0, onehot_opcode(OPC_LOAD), 3'd2, '0,
                      (lcg_next() & ~32'h3) | 32'h2);
        run_exception("load half", 0, 0, 0, onehot_opcode(OPC_LOAD), 3'd1, '0,
                      lcg_next() | 32'h1);
        run_exception("store word", 0, 0, 0, onehot_opcode(OPC_STORE), 3'd2, '0,
                      (lcg_next() & ~32'h3) | 32'h3);
        run_exception("store half", 0, 0, 0, onehot_opcode(OPC_STORE), 3'd1, '0,
                      lcg_next() | 32'h1);
    endtask

    task automatic interrupt_trap();
        xlen_t rd;
        logic  seen;
        int    extra;
        csr_op(F3_CSRRW, ADDR_MTVEC, 32'h0000_2000, '0, rd);     // direct mode
        csr_op(F3_CSRRW, ADDR_MIE, (32'd1 << BIT_MEI) | (32'd1 << BIT_MSI), '0, rd);
        csr_op(F3_CSRRSI, ADDR_MSTATUS, '0, 32'd1 << BIT_MIE, rd);
        mepc_model = lcg_next() & ~32'h3;
        i_pc       = mepc_model;
        i_ext_irq  = 1'b1;
        i_sw_irq   = 1'b1;
        wait_trap("ext+sw interrupt", seen);
        check_data("direct trap address", 32'h0000_2000, o_trap_address);
        extra = 0;
        for (int i = 0; i < 8; i++) begin                        // lines still held
            step();
            if (o_go_to_trap_q)
                extra++;
        end
        if (extra != 0)
            report_failure($sformatf("held interrupt entered the trap %0d more times", extra));
        i_ext_irq = 1'b0;
        i_sw_irq  = 1'b0;
        csr_read(ADDR_MCAUSE, rd);
        check_data("irq mcause", {1'b1, 27'd0, expected_cause(1, 1, 0, 0, 0, 0, 0, 0)}, rd);
        csr_read(ADDR_MSTATUS, rd);
        check_data("mstatus in trap", 32'h0000_1800 | (32'd1 << BIT_MPIE), rd);
        csr_read(ADDR_MEPC, rd);
        check_data("irq mepc", mepc_model, rd);
    endtask

    task automatic trap_return();
        xlen_t rd;
        do_mret();
        check_bit("return_from_trap", 1'b1, o_return_from_trap_q);
        check_data("return address", mepc_model, o_return_address);
        csr_read(ADDR_MSTATUS, rd);
        check_data("mstatus after mret",
                   32'h0000_1800 | (32'd1 << BIT_MPIE) | (32'd1 << BIT_MIE), rd);
    endtask

    task automatic vectored_addresses();
        xlen_t base;
        xlen_t rd;
        logic  seen;
        base = 32'h0000_3000;
        csr_op(F3_CSRRW, ADDR_MTVEC, base | 32'h1, '0, rd);    // vectored mode
        i_sw_irq = 1'b1;
        wait_trap("software interrupt", seen);
        check_data("vectored sw irq address",
                   base + (xlen_t'(expected_cause(0, 1, 0, 0, 0, 0, 0, 0)) << 2), o_trap_address);
        i_sw_irq = 1'b0;
        step();
        do_mret();                                    // global enable back on
        run_exception("vectored ecall", 0, 1, 0, '0, 3'd0, '0, '0);
        check_data("vectored ecall address", base, o_trap_address);
    endtask

    initial begin
        #(6 * 200 * 100);                             // 6 tests of 200 cycles each
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        lcg_state      = 32'd93717;
        error_count    = 0;
        check_count    = 0;
        mscratch_model = '0;
        mepc_model     = '0;
        i_rst_n        = 1'b0;
        i_ext_irq      = 1'b0;
        i_sw_irq       = 1'b0;
        i_pc           = '0;
        drive_idle();
        repeat (16) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        check_data("csr_out after reset", '0, o_csr_out);
        check_bit("go_to_trap after reset", 1'b0, o_go_to_trap_q);
        check_bit("return_from_trap after reset", 1'b0, o_return_from_trap_q);
        mscratch_rmw_ops();
        read_only_csrs();
        exception_traps();
        interrupt_trap();
        trap_return();
        vectored_addresses();
        step();
        error_count += int'(u_dut.u_trap_ctrl.u_checker.fail_count);
        $display("checks: %0d, errors: %0d (assertion failures: %0d)", check_count,
                 error_count, u_dut.u_trap_ctrl.u_checker.fail_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* csr_unit.f */
source/csr_pkg.sv
source/trap_detect.sv
source/csr_regfile.sv
source/trap_ctrl.sv
source/csr_unit.sv
tests/csr_unit_checker.sv
tests/tb_csr_unit.sv

/* run.sh */
#!/bin/sh
# compile and run the csr_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -j 0 --top-module tb_csr_unit \
    -f csr_unit.f -o sim_csr_unit || exit 1
out="$(./obj_dir/sim_csr_unit)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED" && echo "run.sh: pass" \
    || { echo "run.sh: fail"; exit 1; }
